/* logic/isa_pkg.sv */
package isa_pkg;

  // instruction word and address width.
  typedef logic [31:0] word_t;

  typedef logic [4:0] reg_idx_t;

  // sign-extended immediate.
  typedef logic [31:0] imm_t;

  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_load,
    op_store,
    op_alu_imm,
    op_alu_reg,
    op_illegal
  } op_class_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoded instruction.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    word_t     pc;
    op_class_t op_class;
    logic [2:0] funct3;
    reg_idx_t  dest_reg;
    logic      dest_reg_valid;
    reg_idx_t  src1_reg;
    reg_idx_t  src2_reg;
    imm_t      imm;
  } dec_inst_t;

endpackage

/* logic/frontend_pkg.sv */
package frontend_pkg;

  import isa_pkg::*;

  // lanes per fetch group.
  localparam int group_width = 4;

  // width of the slot field in a queue entry.
  localparam int rob_slot_bits = 8;

  typedef logic stream_t;

  // items in a group, 0 to 4.
  typedef logic [2:0] slot_count_t;

  typedef struct packed {
    word_t [group_width-1:0] words;
    word_t [group_width-1:0] pcs;
    logic [group_width-1:0]  lane_valid;
    stream_t                 stream;
  } fetch_group_t;

  typedef struct packed {
    dec_inst_t                inst;
    logic [rob_slot_bits-1:0] rob_slot;
    stream_t                  stream;
  } iq_entry_t;

endpackage

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*; (
  input  word_t     inst_word,
  input  word_t     pc,
  output dec_inst_t dec
);

  op_class_t op_class;
  imm_t      imm_i;
  imm_t      imm_s;
  imm_t      imm_b;
  imm_t      imm_u;
  imm_t      imm_j;
  logic      writes_reg;

  // full 7-bit opcode, so compressed words fall to illegal.
  always_comb begin
    case (inst_word[6:0])
      7'b0110111: op_class = op_lui;
      7'b0010111: op_class = op_auipc;
      7'b1101111: op_class = op_jal;
      7'b1100111: op_class = op_jalr;
      7'b1100011: op_class = op_branch;
      7'b0000011: op_class = op_load;
      7'b0100011: op_class = op_store;
      7'b0010011: op_class = op_alu_imm;
      7'b0110011: op_class = op_alu_reg;
      default:    op_class = op_illegal;
    endcase
  end

  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                  inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u = {inst_word[31:12], 12'b0};
  assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                  inst_word[20], inst_word[30:21], 1'b0};

  assign writes_reg = (op_class != op_store) && (op_class != op_branch) &&
                      (op_class != op_illegal);

  always_comb begin
    dec.pc             = pc;
    dec.op_class       = op_class;
    dec.funct3         = inst_word[14:12];
    dec.dest_reg       = inst_word[11:7];
    // x0 is never a real destination.
    dec.dest_reg_valid = writes_reg && (inst_word[11:7] != 5'd0);
    dec.src1_reg       = inst_word[19:15];
    dec.src2_reg       = inst_word[24:20];
    case (op_class)
      op_lui, op_auipc:              dec.imm = imm_u;
      op_jal:                        dec.imm = imm_j;
      op_jalr, op_load, op_alu_imm:  dec.imm = imm_i;
      op_branch:                     dec.imm = imm_b;
      op_store:                      dec.imm = imm_s;
      default:                       dec.imm = '0;
    endcase
  end

endmodule

/* logic/flush_tracker.sv */
`timescale 1ns/1ps

module flush_tracker import frontend_pkg::*; (
  input  logic    clock,
  input  logic    reset_n,
  input  logic    flush,
  input  stream_t flush_stream,
  input  stream_t group_stream,
  output logic    drop_group
);

  typedef enum logic {
    st_idle,
    st_draining
  } flush_state_t;

  flush_state_t state;
  stream_t      held_stream;
  logic         flush_hit;
  logic         drain_hit;

  assign flush_hit  = flush && (flush_stream == group_stream);
  assign drain_hit  = (state == st_draining) && (group_stream == held_stream);
  assign drop_group = flush_hit | drain_hit;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state       <= st_idle;
      held_stream <= 1'b0;
    end else if (flush_hit) begin
      state       <= st_draining;
      held_stream <= flush_stream;
    end else if ((state == st_draining) && (group_stream != held_stream)) begin
      // fetch has moved to the other stream.
      state <= st_idle;
    end
  end

endmodule

/* logic/rob_allocator.sv */
`timescale 1ns/1ps

module rob_allocator import frontend_pkg::*; #(
  parameter int rob_depth_log2 = 4
) (
  input  logic                                       clock,
  input  logic                                       reset_n,
  input  logic                                       accept,
  input  slot_count_t                                accept_count,
  input  slot_count_t                                retire_count,
  output logic [group_width-1:0][rob_depth_log2-1:0] reserved_slots,
  output logic                                       rob_full
);

  localparam int depth = 1 << rob_depth_log2;

  logic [rob_depth_log2-1:0] tail;
  logic [rob_depth_log2:0]   count;
  logic [rob_depth_log2:0]   added;

  // next four slots, wrapping with the pointer width.
  always_comb begin
    for (int k = 0; k < group_width; k++) begin
      reserved_slots[k] = tail + rob_depth_log2'(k);
    end
  end

  // full once fewer than a whole group of slots is free.
  assign rob_full = count > (rob_depth_log2 + 1)'(depth - group_width);

  assign added = accept ? (rob_depth_log2 + 1)'(accept_count) : '0;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      tail  <= '0;
      count <= '0;
    end else begin
      if (accept) begin
        tail <= tail + rob_depth_log2'(accept_count);
      end
      count <= count + added - (rob_depth_log2 + 1)'(retire_count);
    end
  end

endmodule

/* logic/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue import frontend_pkg::*; #(
  parameter int iq_depth_log2 = 3
) (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        insert,
  input  slot_count_t                 insert_count,
  input  iq_entry_t [group_width-1:0] new_entries,
  input  logic                        issue_ready,
  output logic                        issue_valid,
  output iq_entry_t                   issue_entry,
  output logic                        iq_full
);

  localparam int depth = 1 << iq_depth_log2;

  iq_entry_t                mem [depth];
  logic [iq_depth_log2-1:0] head;
  logic [iq_depth_log2-1:0] tail;
  logic [iq_depth_log2:0]   fill;
  logic [iq_depth_log2:0]   added;
  logic                     pop;

  assign issue_valid = fill != '0;
  assign issue_entry = mem[head];
  assign pop         = issue_valid & issue_ready;

  // room for a full group is always kept.
  assign iq_full = fill > (iq_depth_log2 + 1)'(depth - group_width);

  assign added = insert ? (iq_depth_log2 + 1)'(insert_count) : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    for (int k = 0; k < group_width; k++) begin
      if (insert && (slot_count_t'(k) < insert_count)) begin
        mem[tail + iq_depth_log2'(k)] <= new_entries[k];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head <= '0;
      tail <= '0;
      fill <= '0;
    end else begin
      if (insert) begin
        tail <= tail + iq_depth_log2'(insert_count);
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      fill <= fill + added - {{iq_depth_log2{1'b0}}, pop};
    end
  end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, frontend_pkg::*; #(
  parameter int rob_depth_log2 = 4
) (
  input  fetch_group_t                              fetch,
  input  dec_inst_t [group_width-1:0]               decoded,
  input  logic                                      drop_group,
  input  logic [group_width-1:0][rob_depth_log2-1:0] reserved_slots,
  input  logic                                      rob_full,
  input  logic                                      iq_full,
  output logic                                      stall,
  output logic                                      accept,
  output slot_count_t                               accept_count,
  output iq_entry_t [group_width-1:0]               new_entries
);

  logic        any_valid;
  slot_count_t valid_count;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compaction toward entry 0.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    slot_count_t pos;
    pos = '0;
    for (int k = 0; k < group_width; k++) begin
      new_entries[k].inst     = '0;
      new_entries[k].rob_slot = rob_slot_bits'(reserved_slots[k]);
      new_entries[k].stream   = fetch.stream;
    end
    for (int i = 0; i < group_width; i++) begin
      if (fetch.lane_valid[i]) begin
        new_entries[pos].inst = decoded[i];
        pos = pos + 3'd1;
      end
    end
    valid_count = pos;
  end

  assign any_valid = |fetch.lane_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stall and accept.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign stall = rob_full | iq_full;

  // one pulse reserves slots and inserts queue entries.
  assign accept = ~stall & any_valid & ~drop_group;

  assign accept_count = valid_count;

endmodule

/* logic/decode_top.sv */
`timescale 1ns/1ps

module decode_top import isa_pkg::*, frontend_pkg::*; #(
  parameter int rob_depth_log2 = 4,
  parameter int iq_depth_log2  = 3
) (
  input  logic         clock,
  input  logic         reset_n,
  input  fetch_group_t fetch,
  input  logic         flush,
  input  stream_t      flush_stream,
  input  slot_count_t  retire_count,
  input  logic         issue_ready,
  output logic         stall,
  output logic         issue_valid,
  output iq_entry_t    issue_entry
);

  dec_inst_t [group_width-1:0]                decoded;
  logic [group_width-1:0][rob_depth_log2-1:0] reserved_slots;
  iq_entry_t [group_width-1:0]                new_entries;
  slot_count_t                                accept_count;
  logic                                       accept;
  logic                                       drop_group;
  logic                                       rob_full;
  logic                                       iq_full;

  // one decoder per lane.
  for (genvar i = 0; i < group_width; i++) begin : g_lane
    inst_decoder u_dec (
      .inst_word (fetch.words[i]),
      .pc        (fetch.pcs[i]),
      .dec       (decoded[i])
    );
  end

  flush_tracker u_flush (
    .clock        (clock),
    .reset_n      (reset_n),
    .flush        (flush),
    .flush_stream (flush_stream),
    .group_stream (fetch.stream),
    .drop_group   (drop_group)
  );

  decode_stage #(.rob_depth_log2(rob_depth_log2)) u_stage (
    .fetch          (fetch),
    .decoded        (decoded),
    .drop_group     (drop_group),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full),
    .iq_full        (iq_full),
    .stall          (stall),
    .accept         (accept),
    .accept_count   (accept_count),
    .new_entries    (new_entries)
  );

  rob_allocator #(.rob_depth_log2(rob_depth_log2)) u_rob (
    .clock          (clock),
    .reset_n        (reset_n),
    .accept         (accept),
    .accept_count   (accept_count),
    .retire_count   (retire_count),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full)
  );

  issue_queue #(.iq_depth_log2(iq_depth_log2)) u_iq (
    .clock        (clock),
    .reset_n      (reset_n),
    .insert       (accept),
    .insert_count (accept_count),
    .new_entries  (new_entries),
    .issue_ready  (issue_ready),
    .issue_valid  (issue_valid),
    .issue_entry  (issue_entry),
    .iq_full      (iq_full)
  );

endmodule

/* verification/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb import isa_pkg::*, frontend_pkg::*; ();

  localparam int rob_log2  = 4;
  localparam int iq_log2   = 3;
  localparam int rob_depth = 1 << rob_log2;
  localparam int iq_depth  = 1 << iq_log2;

  // one stimulus row. widx holds a pool index per lane, lane 0 in the low nibble.
  typedef struct packed {
    logic [3:0]  mask;
    logic [15:0] widx;
    stream_t     stream;
    logic        flush;
    stream_t     flush_stream;
    slot_count_t retire;
    logic        ready;
  } row_t;

  typedef struct packed {
    word_t      pc;
    op_class_t  op;
    reg_idx_t   rd;
    logic       rd_valid;
    imm_t       imm;
    logic [7:0] slot;
    stream_t    stream;
  } expect_t;

  logic         clock = 1'b0;
  logic         reset_n;
  fetch_group_t fetch;
  logic         flush;
  stream_t      flush_stream;
  slot_count_t  retire_count;
  logic         issue_ready;
  logic         stall;
  logic         issue_valid;
  iq_entry_t    issue_entry;

  word_t     pool_word [16];
  op_class_t pool_op [16];
  reg_idx_t  pool_rd [16];
  logic      pool_rd_valid [16];
  imm_t      pool_imm [16];

  row_t         rows [$];
  expect_t      exp_q [$];
  row_t         cur_row;
  fetch_group_t cur_fetch;
  slot_count_t  cur_retire;
  logic         cur_ready;
  logic         rows_ready = 1'b0;
  logic [31:0]  lcg_state = 32'd50932;
  int           rob_occ = 0;
  int           next_slot = 0;
  logic         draining = 1'b0;
  stream_t      held_stream = 1'b0;
  int           stall_cycles = 0;
  int           total_accepted = 0;

  decode_top #(.rob_depth_log2(rob_log2), .iq_depth_log2(iq_log2)) dut (
    .clock        (clock),
    .reset_n      (reset_n),
    .fetch        (fetch),
    .flush        (flush),
    .flush_stream (flush_stream),
    .retire_count (retire_count),
    .issue_ready  (issue_ready),
    .stall        (stall),
    .issue_valid  (issue_valid),
    .issue_entry  (issue_entry)
  );

  always #2 clock = ~clock;

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %0h expected %0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic set_word(input int idx, input word_t w, input op_class_t op,
                          input reg_idx_t rd, input logic rd_valid, input imm_t imm);
    pool_word[idx]     = w;
    pool_op[idx]       = op;
    pool_rd[idx]       = rd;
    pool_rd_valid[idx] = rd_valid;
    pool_imm[idx]      = imm;
  endtask

  task automatic add_row(input logic [3:0] mask, input logic [15:0] widx, input stream_t stream,
                         input logic fl, input stream_t fs, input slot_count_t retire,
                         input logic ready);
    row_t r;
    r.mask         = mask;
    r.widx         = widx;
    r.stream       = stream;
    r.flush        = fl;
    r.flush_stream = fs;
    r.retire       = retire;
    r.ready        = ready;
    rows.push_back(r);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic build_rows();
    logic [31:0] r;
    logic [15:0] widx;
    set_word(0, 32'h123452B7, op_lui,     5'd5,  1'b1, 32'h12345000);
    set_word(1, 32'h008000EF, op_jal,     5'd1,  1'b1, 32'h00000008);
    set_word(2, 32'hFFC12383, op_load,    5'd7,  1'b1, 32'hFFFFFFFC);
    set_word(3, 32'h00312623, op_store,   5'd12, 1'b0, 32'h0000000C);
    set_word(4, 32'hFE208CE3, op_branch,  5'd25, 1'b0, 32'hFFFFFFF8);
    set_word(5, 32'hFFF00513, op_alu_imm, 5'd10, 1'b1, 32'hFFFFFFFF);
    set_word(6, 32'h00208033, op_alu_reg, 5'd0,  1'b0, 32'h00000000);
    set_word(7, 32'h00004501, op_illegal, 5'd10, 1'b0, 32'h00000000);
    set_word(8, 32'h00001197, op_auipc,   5'd3,  1'b1, 32'h00001000);
    set_word(9, 32'h00008067, op_jalr,    5'd0,  1'b0, 32'h00000000);
    // full and sparse lane masks.
    add_row(4'hF, 16'h3210, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1);
    add_row(4'hF, 16'h7654, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1);
    add_row(4'h5, 16'h1098, 1'b0, 1'b0, 1'b0, 3'd2, 1'b1);
    add_row(4'hA, 16'h5432, 1'b0, 1'b0, 1'b0, 3'd2, 1'b1);
    add_row(4'h0, 16'h0000, 1'b0, 1'b0, 1'b0, 3'd4, 1'b1);
    add_row(4'h8, 16'h9876, 1'b0, 1'b0, 1'b0, 3'd4, 1'b1);
    // stream 0 flushed until fetch moves to stream 1.
    add_row(4'hF, 16'h3210, 1'b0, 1'b1, 1'b0, 3'd4, 1'b1);
    add_row(4'h3, 16'h7654, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1);
    add_row(4'hF, 16'h9854, 1'b1, 1'b0, 1'b0, 3'd4, 1'b1);
    add_row(4'h3, 16'h2100, 1'b1, 1'b1, 1'b0, 3'd2, 1'b1);
    add_row(4'hF, 16'h6543, 1'b0, 1'b0, 1'b0, 3'd4, 1'b1);
    add_row(4'h6, 16'h0987, 1'b0, 1'b1, 1'b1, 3'd2, 1'b1);
    // consumer stopped, nothing retires.
    add_row(4'hF, 16'h3210, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0);
    add_row(4'hF, 16'h7654, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0);
    add_row(4'hF, 16'h1098, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0);
    add_row(4'hF, 16'h5432, 1'b0, 1'b0, 1'b0, 3'd4, 1'b1);
    for (int k = 0; k < 24; k++) begin
      r = next_random();
      for (int i = 0; i < group_width; i++) begin
        widx[i*4 +: 4] = 4'((next_random() >> 16) % 10);
      end
      add_row(r[19:16], widx, r[20], r[27:24] == 4'd0, r[21],
              slot_count_t'((r >> 28) % 5), r[23:22] != 2'b00);
    end
  endtask

  task automatic drive_group(input row_t r, input int row_no, input logic release_hold);
    fetch_group_t fg;
    slot_count_t  ret;
    fg.lane_valid = r.mask;
    fg.stream     = r.stream;
    for (int i = 0; i < group_width; i++) begin
      fg.words[i] = pool_word[r.widx[i*4 +: 4]];
      fg.pcs[i]   = 32'h1000 + 32'(row_no * 16 + i * 4);
    end
    // a held group drains the queue and retires slots.
    ret = release_hold ? 3'd4 : r.retire;
    if (int'(ret) > rob_occ) begin
      ret = slot_count_t'(rob_occ);
    end
    cur_row      = r;
    cur_fetch    = fg;
    cur_retire   = ret;
    cur_ready    = release_hold | r.ready;
    fetch        <= fg;
    flush        <= r.flush;
    flush_stream <= r.flush_stream;
    retire_count <= ret;
    issue_ready  <= cur_ready;
  endtask

  task automatic compare_head();
    expect_t e;
    e = exp_q.pop_front();
    check_value(64'(issue_entry.inst.pc), 64'(e.pc), "issue pc");
    check_value(64'(issue_entry.inst.op_class), 64'(e.op), "op_class");
    check_value(64'(issue_entry.inst.dest_reg), 64'(e.rd), "dest_reg");
    check_value(64'(issue_entry.inst.dest_reg_valid), 64'(e.rd_valid), "dest_reg_valid");
    check_value(64'(issue_entry.inst.imm), 64'(e.imm), "imm");
    check_value(64'(issue_entry.rob_slot), 64'(e.slot), "rob slot");
    check_value(64'(issue_entry.stream), 64'(e.stream), "stream");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model, one cycle.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step_model(output logic advance);
    logic       exp_stall;
    logic       drop;
    logic       pop;
    logic [3:0] w;
    int         n;
    expect_t    e;
    exp_stall = (rob_occ > rob_depth - group_width) ||
                (exp_q.size() > iq_depth - group_width);
    check_value(64'(stall), 64'(exp_stall), "stall");
    check_value(64'(issue_valid), 64'(exp_q.size() != 0), "issue_valid");
    if (stall) begin
      stall_cycles++;
    end
    pop = cur_ready && (exp_q.size() != 0);
    if (pop) begin
      compare_head();
    end
    drop = (cur_row.flush && (cur_row.flush_stream == cur_fetch.stream)) ||
           (draining && (cur_fetch.stream == held_stream));
    n = 0;
    if (!exp_stall && (cur_fetch.lane_valid != 4'd0) && !drop) begin
      for (int i = 0; i < group_width; i++) begin
        if (cur_fetch.lane_valid[i]) begin
          w          = cur_row.widx[i*4 +: 4];
          e.pc       = cur_fetch.pcs[i];
          e.op       = pool_op[w];
          e.rd       = pool_rd[w];
          e.rd_valid = pool_rd_valid[w];
          e.imm      = pool_imm[w];
          e.slot     = 8'(next_slot);
          e.stream   = cur_fetch.stream;
          exp_q.push_back(e);
          next_slot = (next_slot + 1) % rob_depth;
          n++;
        end
      end
    end
    rob_occ        = rob_occ + n - int'(cur_retire);
    total_accepted = total_accepted + n;
    if (cur_row.flush && (cur_row.flush_stream == cur_fetch.stream)) begin
      draining    = 1'b1;
      held_stream = cur_row.flush_stream;
    end else if (draining && (cur_fetch.stream != held_stream)) begin
      draining = 1'b0;
    end
    advance = !exp_stall;
  endtask

  initial begin
    int   idx;
    logic held;
    logic advance;
    row_t idle;
    reset_n      = 1'b0;
    fetch        = '0;
    flush        = 1'b0;
    flush_stream = 1'b0;
    retire_count = '0;
    issue_ready  = 1'b0;
    build_rows();
    rows_ready = 1'b1;
    idle       = '0;
    idle.ready = 1'b1;
    repeat (10) @(posedge clock);
    reset_n <= 1'b1;
    idx  = 0;
    held = 1'b0;
    while (idx < rows.size()) begin
      @(posedge clock);
      drive_group(rows[idx], idx, held);
      @(negedge clock);
      step_model(advance);
      if (advance) begin
        idx++;
        held = 1'b0;
      end else begin
        held = 1'b1;
      end
    end
    // empty groups until every entry has issued.
    while (exp_q.size() != 0) begin
      @(posedge clock);
      drive_group(idle, idx, 1'b1);
      @(negedge clock);
      step_model(advance);
    end
    // no entry left over once the last one has been taken.
    @(negedge clock);
    check_value(64'(issue_valid), 64'd0, "queue empty after drain");
    check_value(64'(stall_cycles != 0), 64'd1, "stall under back-pressure");
    check_value(64'(total_accepted > rob_depth), 64'd1, "slot wraparound");
    $display("Regression passed");
    $finish;
  end

  initial begin
    int limit;
    wait (rows_ready);
    limit = rows.size() * 40;
    repeat (limit) @(posedge clock);
    $display("[FAIL] t=%0t watchdog timeout, run not done after %0d cycles", $time, limit);
    $display("Regression failed");
    $fatal(1, "timeout");
  end

endmodule

/* filelist.f */
logic/isa_pkg.sv
logic/frontend_pkg.sv
logic/inst_decoder.sv
logic/flush_tracker.sv
logic/rob_allocator.sv
logic/issue_queue.sv
logic/decode_stage.sv
logic/decode_top.sv
verification/decode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
